//--- oled_pkg.sv
/* Step and byte tables for the SSD1331 power-up sequence. Command bytes only,
   so dc is low for the whole sequence. Wait times are given in microseconds. */
`default_nettype none

package oled_pkg;

    // What a step of the sequence does.
    typedef enum logic [1:0] {
        STEP_SET_PINS,
        STEP_WAIT,
        STEP_SEND_BYTES,
        STEP_DONE
    } step_kind_t;

    // Delay selection carried in the step argument.
    typedef enum logic [1:0] {
        WAIT_3_US,
        WAIT_20_MS,
        WAIT_25_MS,
        WAIT_100_MS
    } wait_sel_t;

    // Bit positions in the pin word, dc at the MSB.
    localparam int PIN_DC     = 3;
    localparam int PIN_RES    = 2;
    localparam int PIN_VCCEN  = 1;
    localparam int PIN_PMODEN = 0;

    // Pin words used by the step table.
    localparam logic [3:0] PINS_PMODEN     = 4'(1 << PIN_PMODEN);
    localparam logic [3:0] PINS_RES_PMODEN = 4'(1 << PIN_RES) | PINS_PMODEN;
    localparam logic [3:0] PINS_VCC_ON     = 4'(1 << PIN_VCCEN) | PINS_RES_PMODEN;

    // Length of each delay in microseconds, indexed by wait_sel_t.
    localparam int unsigned WAIT_US_TABLE [4] = '{3, 20000, 25000, 100000};

    // Six power-up steps, 22 command bursts, then vccen and display on.
    localparam int NUM_STEPS    = 33;
    localparam int STEP_INDEX_W = 6;

    localparam step_kind_t STEP_KIND_TABLE [NUM_STEPS] = '{
        // Logic supply on, then a low pulse on res.
        STEP_SET_PINS, STEP_WAIT, STEP_SET_PINS, STEP_WAIT, STEP_SET_PINS, STEP_WAIT,
        // Unlock, setup and screen clear.
        STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES,
        STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES,
        STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES,
        STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES, STEP_SEND_BYTES,
        STEP_SEND_BYTES, STEP_SEND_BYTES,
        // Panel supply on, display on, settle.
        STEP_SET_PINS, STEP_WAIT, STEP_SEND_BYTES, STEP_WAIT, STEP_DONE
    };

    // Pin word, wait selection or byte count, depending on the step kind.
    localparam logic [3:0] STEP_ARG_TABLE [NUM_STEPS] = '{
        PINS_RES_PMODEN, 4'(WAIT_20_MS), PINS_PMODEN, 4'(WAIT_3_US),
        PINS_RES_PMODEN, 4'(WAIT_3_US),
        // FD 12, AE, A0 72, A1 00, A2 00, A4.
        4'd2, 4'd1, 4'd2, 4'd2, 4'd2, 4'd1,
        // A8 through 83, one argument each.
        4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd2,
        4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd2, 4'd2,
        // Scroll off, then the clear window.
        4'd1, 4'd5,
        PINS_VCC_ON, 4'(WAIT_25_MS), 4'd1, 4'(WAIT_100_MS), 4'd0
    };

    // Command bytes in send order.
    localparam int NUM_BYTES    = 45;
    localparam int BYTE_INDEX_W = 6;

    localparam logic [7:0] BYTE_TABLE [NUM_BYTES] = '{
        // Unlock, display off, remap, start line, offset, normal mode.
        8'hFD, 8'h12, 8'hAE, 8'hA0, 8'h72, 8'hA1, 8'h00, 8'hA2, 8'h00, 8'hA4,
        // Mux ratio, master config, power save off, phase length, clock.
        8'hA8, 8'h3F, 8'hAD, 8'h8E, 8'hB0, 8'h0B, 8'hB1, 8'h31, 8'hB3, 8'hF0,
        // Second precharge A B C, precharge level, VCOMH.
        8'h8A, 8'h64, 8'h8B, 8'h78, 8'h8C, 8'h64, 8'hBB, 8'h3A, 8'hBE, 8'h3E,
        // Master current and contrast A B C.
        8'h87, 8'h06, 8'h81, 8'h91, 8'h82, 8'h50, 8'h83, 8'h7D,
        // Scroll off, clear the full 96x64 window.
        8'h2E, 8'h25, 8'h00, 8'h00, 8'h5F, 8'h3F,
        // Display on.
        8'hAF
    };

    // Idle cycles with cs high after each burst.
    localparam int SPI_GAP_CYCLES = 4;
    localparam int SPI_GAP_W      = $clog2(SPI_GAP_CYCLES + 1);

endpackage

`default_nettype wire

//--- oled_delay_timer.sv
/* Delay timer for the power-up waits. Counts are floor(f * us / 1e6), at least 1.
   A new start must not arrive while a wait is running. */
`default_nettype none

module oled_delay_timer #(
    parameter int CLOCK_FREQUENCY = 12000000
) (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                wait_start,
    input  oled_pkg::wait_sel_t wait_sel,
    output logic                wait_done
);
    import oled_pkg::*;

    // Cycle count for a delay in microseconds.
    function automatic longint cycles_for(longint us);
        longint cycles;
        cycles = (longint'(CLOCK_FREQUENCY) * us) / 1000000;
        return (cycles < 1) ? 1 : cycles;
    endfunction

    localparam longint CYCLES_3_US   = cycles_for(longint'(WAIT_US_TABLE[WAIT_3_US]));
    localparam longint CYCLES_20_MS  = cycles_for(longint'(WAIT_US_TABLE[WAIT_20_MS]));
    localparam longint CYCLES_25_MS  = cycles_for(longint'(WAIT_US_TABLE[WAIT_25_MS]));
    localparam longint CYCLES_100_MS = cycles_for(longint'(WAIT_US_TABLE[WAIT_100_MS]));
    localparam int     CNT_W         = $clog2(CYCLES_100_MS + 1);

    logic [CNT_W-1:0] sel_cycles;
    logic [CNT_W-1:0] target;
    logic [CNT_W-1:0] count;
    logic             busy;

    // Selection to cycle count.
    always_comb begin
        case (wait_sel)
            WAIT_3_US:   sel_cycles = CNT_W'(CYCLES_3_US);
            WAIT_20_MS:  sel_cycles = CNT_W'(CYCLES_20_MS);
            WAIT_25_MS:  sel_cycles = CNT_W'(CYCLES_25_MS);
            default:     sel_cycles = CNT_W'(CYCLES_100_MS);
        endcase
    end

    // Cycle count of the wait in progress.
    always_ff @(posedge clock) begin
        if (wait_start) begin
            target <= sel_cycles;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            busy      <= 1'b0;
            count     <= '0;
            wait_done <= 1'b0;
        end else begin
            wait_done <= 1'b0;
            if (wait_start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                // Strobe on the cycle after the count is reached.
                if (count == target) begin
                    busy      <= 1'b0;
                    wait_done <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // The sequencer holds off until wait_done.
    a_no_start_while_busy: assert property (
        @(posedge clock) disable iff (!reset_n) wait_start |-> !busy);

endmodule

`default_nettype wire

//--- oled_spi_shifter.sv
/* Write-only SPI master, MSB first, one sck period per two clocks. Idle is cs
   and sck high. The byte pointer only moves forward through the byte table. */
`default_nettype none

module oled_spi_shifter (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       burst_start,
    input  logic [3:0] burst_len,
    output logic       burst_done,
    output logic       cs,
    output logic       sck,
    output logic       mosi
);
    import oled_pkg::*;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_LOW,
        SPI_HIGH,
        SPI_GAP
    } spi_state_t;

    spi_state_t              state;
    logic [BYTE_INDEX_W-1:0] byte_ptr;
    logic [7:0]              shift_reg;
    logic [2:0]              bit_cnt;
    logic [3:0]              bytes_left;
    logic [SPI_GAP_W-1:0]    gap_cnt;
    logic                    last_bit;
    logic                    load_byte;

    assign last_bit = (state == SPI_HIGH) && (bit_cnt == 3'd7);

    // New byte at the start of a burst, or after the last bit of a byte.
    assign load_byte = (state == SPI_IDLE && burst_start) ||
                       (last_bit && bytes_left != 4'd1);

    // Data shifts out of the MSB.
    always_ff @(posedge clock) begin
        if (load_byte) begin
            shift_reg <= BYTE_TABLE[byte_ptr];
        end else if (state == SPI_HIGH) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= SPI_IDLE;
            byte_ptr   <= '0;
            bit_cnt    <= '0;
            bytes_left <= '0;
            gap_cnt    <= '0;
            burst_done <= 1'b0;
            cs         <= 1'b1;
            sck        <= 1'b1;
            mosi       <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            if (load_byte) begin
                byte_ptr <= byte_ptr + 1'b1;
            end
            case (state)
                SPI_IDLE: begin
                    // Start cycle, the first byte is fetched.
                    if (burst_start) begin
                        bytes_left <= burst_len;
                        bit_cnt    <= '0;
                        state      <= SPI_LOW;
                    end
                end
                SPI_LOW: begin
                    // Falling sck with the next bit on mosi.
                    cs    <= 1'b0;
                    sck   <= 1'b0;
                    mosi  <= shift_reg[7];
                    state <= SPI_HIGH;
                end
                SPI_HIGH: begin
                    // Rising sck, the display samples here.
                    sck     <= 1'b1;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit && bytes_left == 4'd1) begin
                        gap_cnt <= '0;
                        state   <= SPI_GAP;
                    end else begin
                        if (last_bit) begin
                            bytes_left <= bytes_left - 1'b1;
                        end
                        state <= SPI_LOW;
                    end
                end
                SPI_GAP: begin
                    // cs released, then a fixed idle gap.
                    cs      <= 1'b1;
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == SPI_GAP_W'(SPI_GAP_CYCLES - 1)) begin
                        burst_done <= 1'b1;
                        state      <= SPI_IDLE;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // Bursts are strictly sequential.
    a_no_start_while_busy: assert property (
        @(posedge clock) disable iff (!reset_n) burst_start |-> state == SPI_IDLE);

    // Burst lengths in the step table add up to the byte table.
    a_ptr_in_range: assert property (
        @(posedge clock) disable iff (!reset_n) byte_ptr <= BYTE_INDEX_W'(NUM_BYTES));

    // sck only toggles inside a cs frame.
    a_sck_in_frame: assert property (
        @(posedge clock) disable iff (!reset_n) !sck |-> !cs);

endmodule

`default_nettype wire

//--- oled_sequencer.sv
/* Walks the step table once after reset, then holds init_done high.
   Waits and bursts are handed off by strobe and finished by strobe. */
`default_nettype none

module oled_sequencer (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                wait_done,
    input  logic                burst_done,
    output logic                wait_start,
    output oled_pkg::wait_sel_t wait_sel,
    output logic                burst_start,
    output logic [3:0]          burst_len,
    output logic                dc,
    output logic                res,
    output logic                vccen,
    output logic                pmoden,
    output logic                init_done
);
    import oled_pkg::*;

    typedef enum logic [1:0] {
        SEQ_FETCH,
        SEQ_BUSY,
        SEQ_DONE
    } seq_state_t;

    seq_state_t              state;
    logic [STEP_INDEX_W-1:0] step_ptr;
    step_kind_t              step_kind;
    logic [3:0]              step_arg;
    logic                    job_done;

    assign step_kind = STEP_KIND_TABLE[step_ptr];
    assign step_arg  = STEP_ARG_TABLE[step_ptr];

    // Done strobe that matches the current step.
    assign job_done = (step_kind == STEP_WAIT) ? wait_done : burst_done;

    // Job arguments, qualified by the start strobes.
    always_ff @(posedge clock) begin
        if (state == SEQ_FETCH) begin
            wait_sel  <= wait_sel_t'(step_arg[1:0]);
            burst_len <= step_arg;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state       <= SEQ_FETCH;
            step_ptr    <= '0;
            wait_start  <= 1'b0;
            burst_start <= 1'b0;
            dc          <= 1'b0;
            res         <= 1'b0;
            vccen       <= 1'b0;
            pmoden      <= 1'b0;
            init_done   <= 1'b0;
        end else begin
            wait_start  <= 1'b0;
            burst_start <= 1'b0;
            case (state)
                SEQ_FETCH: begin
                    case (step_kind)
                        STEP_SET_PINS: begin
                            // Pin steps finish in one cycle.
                            dc       <= step_arg[PIN_DC];
                            res      <= step_arg[PIN_RES];
                            vccen    <= step_arg[PIN_VCCEN];
                            pmoden   <= step_arg[PIN_PMODEN];
                            step_ptr <= step_ptr + 1'b1;
                        end
                        STEP_WAIT: begin
                            wait_start <= 1'b1;
                            state      <= SEQ_BUSY;
                        end
                        STEP_SEND_BYTES: begin
                            burst_start <= 1'b1;
                            state       <= SEQ_BUSY;
                        end
                        default: begin
                            init_done <= 1'b1;
                            state     <= SEQ_DONE;
                        end
                    endcase
                end
                SEQ_BUSY: begin
                    if (job_done) begin
                        step_ptr <= step_ptr + 1'b1;
                        state    <= SEQ_FETCH;
                    end
                end
                // Idle for good, pins hold their last value.
                default: init_done <= 1'b1;
            endcase
        end
    end

    // Done strobes only answer a job this FSM started.
    a_wait_done_expected: assert property (
        @(posedge clock) disable iff (!reset_n)
        wait_done |-> state == SEQ_BUSY && step_kind == STEP_WAIT);

    a_burst_done_expected: assert property (
        @(posedge clock) disable iff (!reset_n)
        burst_done |-> state == SEQ_BUSY && step_kind == STEP_SEND_BYTES);

endmodule

`default_nettype wire

//--- oled_driver.sv
/* Power-up driver for an SSD1331 OLED on a write-only SPI link.
   CLOCK_FREQUENCY sets the wait counts; sck runs at half the clock. */
`default_nettype none

module oled_driver #(
    parameter int CLOCK_FREQUENCY = 12000000
) (
    input  logic clock,
    input  logic reset_n,
    output logic cs,
    output logic sck,
    output logic mosi,
    output logic dc,
    output logic res,
    output logic vccen,
    output logic pmoden,
    output logic init_done
);
    import oled_pkg::*;

    // Sequencer to timer.
    logic      wait_start;
    wait_sel_t wait_sel;
    logic      wait_done;

    // Sequencer to SPI shifter.
    logic       burst_start;
    logic [3:0] burst_len;
    logic       burst_done;

    oled_sequencer oled_sequencer_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .wait_done   (wait_done),
        .burst_done  (burst_done),
        .wait_start  (wait_start),
        .wait_sel    (wait_sel),
        .burst_start (burst_start),
        .burst_len   (burst_len),
        .dc          (dc),
        .res         (res),
        .vccen       (vccen),
        .pmoden      (pmoden),
        .init_done   (init_done)
    );

    oled_delay_timer #(
        .CLOCK_FREQUENCY (CLOCK_FREQUENCY)
    ) oled_delay_timer_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .wait_start (wait_start),
        .wait_sel   (wait_sel),
        .wait_done  (wait_done)
    );

    oled_spi_shifter oled_spi_shifter_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .burst_start (burst_start),
        .burst_len   (burst_len),
        .burst_done  (burst_done),
        .cs          (cs),
        .sck         (sck),
        .mosi        (mosi)
    );

endmodule

`default_nettype wire

//--- tb_oled_driver.sv
/* Self-checking testbench for oled_driver at 1 MHz, so one cycle is one microsecond.
   Bytes and frames are rebuilt from the SPI pins, and event times are taken at negedge. */
`default_nettype none

module tb_oled_driver;
    import oled_pkg::*;

    localparam int CLOCK_HZ      = 1000000;
    localparam int CYCLES_PER_US = CLOCK_HZ / 1000000;
    localparam int CYCLES_PER_MS = CLOCK_HZ / 1000;
    localparam int DRIVE_DELAY   = 10;
    localparam int TAIL_CYCLES   = 200;

    // Command bursts: unlock, setup, one-argument commands, scroll off, clear, display on.
    localparam int NUM_FRAMES = 23;
    localparam int FRAME_LENS [NUM_FRAMES] = '{
        2, 1, 2, 2, 2, 1,
        2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2,
        1, 5, 1
    };

    // All waits, every burst with its gap and start cycle, the tail, and a quarter margin.
    localparam int WAIT_CYCLES = CYCLES_PER_US * (3 + 3 + 20000 + 25000 + 100000);
    localparam int SPI_CYCLES  = NUM_BYTES * 16 + NUM_FRAMES * (SPI_GAP_CYCLES + 2);
    localparam int TIMEOUT_CYCLES = (WAIT_CYCLES + SPI_CYCLES + TAIL_CYCLES) * 5 / 4;

    logic       clock = 1'b0;
    logic       reset_n;
    logic       cs, sck, mosi, dc, res, vccen, pmoden, init_done;
    logic [7:0] out_word;
    logic       sck_prev, cs_prev, res_prev, pmoden_prev, vccen_prev, init_prev;
    logic [7:0] shift_byte;
    logic [7:0] captured [$];
    int         frame_lens [$];
    int         test_errors [1:6];
    int         cycle;
    int         frame_bits, res_rises, res_falls;
    int         pmoden_rise, res_fall, vccen_rise, byte_end;

    assign out_word = {cs, sck, mosi, dc, res, vccen, pmoden, init_done};

    oled_driver #(
        .CLOCK_FREQUENCY (CLOCK_HZ)
    ) oled_driver_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .cs        (cs),
        .sck       (sck),
        .mosi      (mosi),
        .dc        (dc),
        .res       (res),
        .vccen     (vccen),
        .pmoden    (pmoden),
        .init_done (init_done)
    );

    initial begin
        forever #50 clock = ~clock;
    end

    task automatic report_mismatch(input int num, input string name, input longint got,
                                   input longint exp);
        $display("CHECK FAILED at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        test_errors[num]++;
    endtask

    task automatic report_problem(input int num, input string what);
        $display("Test %0d error at time %0t: %s", num, $time, what);
        test_errors[num]++;
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errors[num] == 0) $display("test %0d (%s): ok", num, name);
        else $display("test %0d (%s): FAIL, %0d errors", num, name, test_errors[num]);
    endtask

    // Reset values hold in reset and on the first cycle after release.
    a_reset_values: assert property (@(negedge clock)
        (!reset_n || $rose(reset_n)) |-> out_word == 8'hC0)
        else report_mismatch(1, "{cs,sck,mosi,dc,res,vccen,pmoden,init_done}", out_word, 8'hC0);

    a_dc_low: assert property (@(negedge clock) disable iff (!reset_n) !dc)
        else report_mismatch(2, "dc", dc, 0);
    a_pmoden_held: assert property (@(negedge clock) disable iff (!reset_n) !$fell(pmoden))
        else report_problem(2, "pmoden fell after power-up");
    a_pins_together: assert property (@(negedge clock) disable iff (!reset_n)
        $rose(pmoden) |-> $rose(res))
        else report_problem(2, "pmoden rose without res");
    a_sck_in_frame: assert property (@(negedge clock) disable iff (!reset_n) !sck |-> !cs)
        else report_problem(4, "sck low while cs high");
    a_vccen_held: assert property (@(negedge clock) disable iff (!reset_n) !$fell(vccen))
        else report_problem(5, "vccen fell");
    a_done_held: assert property (@(negedge clock) disable iff (!reset_n) !$fell(init_done))
        else report_problem(6, "init_done fell");
    a_cs_idle_after_done: assert property (@(negedge clock) disable iff (!reset_n)
        init_done |-> cs)
        else report_mismatch(6, "cs", cs, 1);

    // SPI and pin monitor.
    always @(negedge clock) begin
        if (!reset_n) begin
            frame_bits = 0;
            res_rises  = 0;
            res_falls  = 0;
        end else begin
            if (pmoden && !pmoden_prev) pmoden_rise = cycle;
            if (!res && res_prev) begin
                res_falls++;
                res_fall = cycle;
                assert (cycle - pmoden_rise >= 20 * CYCLES_PER_MS)
                    else report_problem(2, "res fell less than 20 ms after power-up");
            end
            if (res && !res_prev) begin
                res_rises++;
                if (res_falls > 0) assert (cycle - res_fall >= 3 * CYCLES_PER_US)
                    else report_problem(2, "res low pulse shorter than 3 us");
            end
            if (vccen && !vccen_prev) begin
                vccen_rise = cycle;
                assert (captured.size() == NUM_BYTES - 1 && captured[$] == 8'h3F)
                    else report_problem(5, "vccen rose before the last clear byte");
            end
            if (!cs && cs_prev) begin
                frame_bits = 0;
                // The display-on byte opens the last frame.
                if (captured.size() == NUM_BYTES - 1)
                    assert (vccen && cycle - vccen_rise >= 25 * CYCLES_PER_MS)
                        else report_problem(5, "display-on byte less than 25 ms after vccen");
            end
            if (!cs && sck && !sck_prev) begin
                shift_byte = {shift_byte[6:0], mosi};
                frame_bits++;
                if (frame_bits % 8 == 0) begin
                    captured.push_back(shift_byte);
                    byte_end = cycle;
                end
            end
            if (cs && !cs_prev) begin
                assert (frame_bits % 8 == 0) else report_problem(4, "cs frame ended inside a byte");
                frame_lens.push_back(frame_bits / 8);
            end
            if (init_done && !init_prev) assert (cycle - byte_end >= 100 * CYCLES_PER_MS)
                else report_problem(6, "init_done less than 100 ms after the last byte");
        end
        {sck_prev, cs_prev, res_prev} = {sck, cs, res};
        {pmoden_prev, vccen_prev, init_prev} = {pmoden, vccen, init_done};
    end

    initial begin : watchdog
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle++;
        end
        $display("Timeout: init_done not reached within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin : main_flow
        int i;
        int total;
        int failing;
        reset_n = 1'b0;
        repeat (2) @(posedge clock);
        #DRIVE_DELAY reset_n = 1'b1;
        repeat (2) @(negedge clock);
        finish_test(1, "reset values");

        while (!init_done) @(negedge clock);
        repeat (TAIL_CYCLES) @(posedge clock);
        @(negedge clock);

        assert (res_rises == 2 && res_falls == 1)
            else report_problem(2, "res did not pulse low exactly once");
        assert (res && pmoden) else report_problem(2, "res or pmoden low at the end");
        finish_test(2, "pin sequence");

        assert (captured.size() == NUM_BYTES)
            else report_mismatch(3, "byte count", captured.size(), NUM_BYTES);
        for (i = 0; i < NUM_BYTES && i < captured.size(); i++)
            assert (captured[i] == BYTE_TABLE[i])
                else report_mismatch(3, $sformatf("byte %0d", i), captured[i], BYTE_TABLE[i]);
        finish_test(3, "command bytes");

        assert (frame_lens.size() == NUM_FRAMES)
            else report_mismatch(4, "frame count", frame_lens.size(), NUM_FRAMES);
        for (i = 0; i < NUM_FRAMES && i < frame_lens.size(); i++)
            assert (frame_lens[i] == FRAME_LENS[i])
                else report_mismatch(4, $sformatf("frame %0d length", i), frame_lens[i],
                                     FRAME_LENS[i]);
        finish_test(4, "SPI framing");

        assert (vccen) else report_mismatch(5, "vccen", vccen, 1);
        finish_test(5, "panel supply");
        assert (init_done) else report_mismatch(6, "init_done", init_done, 1);
        finish_test(6, "init done");

        total   = 0;
        failing = 0;
        for (i = 1; i <= 6; i++) begin
            total += test_errors[i];
            if (test_errors[i] != 0) failing++;
        end
        $display("tests run 6, tests failing %0d, errors %0d", failing, total);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
oled_pkg.sv
oled_delay_timer.sv
oled_spi_shifter.sv
oled_sequencer.sv
oled_driver.sv
tb_oled_driver.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_oled_driver
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
